// ==== logic_analyser.f ====
+incdir+include
design/la_pkg.sv
design/la_ctrl_if.sv
design/trigger_qualifier.sv
design/capture_engine.sv
design/host_mailbox.sv
design/logic_analyser.sv
tb/la_checker.sv
tb/tb_logic_analyser.sv

// ==== Makefile ====
# Verilator build and run for the logic analyser testbench

VERILATOR ?= verilator
TOP ?= tb_logic_analyser
FILELIST ?= logic_analyser.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal

SOURCES := $(wildcard design/*.sv) $(wildcard tb/*.sv) $(wildcard include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass or fail comes from the log, not the exit code
run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q ">>> PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/tb_logic_analyser.sv ====
`timescale 1ns/1ns
`include "la_config.svh"

module tb_logic_analyser;

	// budget: reset, wrap run, 2000 idle cycles, three captures and config
	localparam int TIMEOUT_CYCLES = 20000;

	logic CLOCK_100;
	logic reset;
	logic [31:0] data_input;
	logic [31:0] trigger_source;
	logic [9:0] sample_addr;
	logic [31:0] sample_wdata;
	logic sample_write;
	logic [7:0] ctrl_addr;
	logic [31:0] ctrl_wdata;
	logic ctrl_write;
	logic [31:0] ctrl_rdata;

	// host memory models
	logic [31:0] ctrl_mem [0:255];
	logic [31:0] sample_mem [0:1023];
	logic [31:0] cfg_mask, cfg_value, cfg_post, cfg_arm;
	logic force_en;
	logic [31:0] force_pattern;
	integer seed;
	int cycles;
	int tests_run, tests_failed;
	int errors_before, captures_before;
	int error_count, capture_count;
	logic [31:0] exp_sample;
	int post_list [3];

	logic_analyser u_logic_analyser (
		.CLOCK_100 (CLOCK_100),
		.reset (reset),
		.data_input (data_input),
		.trigger_source (trigger_source),
		.sample_addr (sample_addr),
		.sample_wdata (sample_wdata),
		.sample_write (sample_write),
		.ctrl_addr (ctrl_addr),
		.ctrl_wdata (ctrl_wdata),
		.ctrl_write (ctrl_write),
		.ctrl_rdata (ctrl_rdata)
	);

	la_checker u_checker (
		.CLOCK_100 (CLOCK_100), .reset (reset),
		.data_input (data_input), .trigger_source (trigger_source),
		.sample_addr (sample_addr), .sample_wdata (sample_wdata),
		.sample_write (sample_write), .ctrl_addr (ctrl_addr),
		.ctrl_wdata (ctrl_wdata), .ctrl_write (ctrl_write),
		.cfg_mask (cfg_mask), .cfg_value (cfg_value),
		.cfg_post (cfg_post), .cfg_arm (cfg_arm),
		.new_word (ctrl_mem[`LA_ADDR_NEW]), .done_word (ctrl_mem[`LA_ADDR_DONE]),
		.error_count (error_count), .capture_count (capture_count),
		.exp_sample (exp_sample)
	);

	// ============================================================
	// clock, stimulus and memories
	// ============================================================

	always #20 CLOCK_100 = ~CLOCK_100;

	// counter data, random trigger source unless a pattern is forced
	always @(posedge CLOCK_100) begin
		if (!reset) begin
			data_input <= data_input + 1;
		end
		trigger_source <= force_en ? force_pattern : $random(seed);
	end

	// registered read, one edge behind the address
	always @(posedge CLOCK_100) begin
		if (ctrl_write) begin
			ctrl_mem[ctrl_addr] <= ctrl_wdata;
		end
		ctrl_rdata <= ctrl_mem[ctrl_addr];
		if (sample_write) begin
			sample_mem[sample_addr] <= sample_wdata;
		end
	end

	always @(posedge CLOCK_100) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display(">>> FAIL");
			$finish;
		end
	end

	// ============================================================
	// host behaviour
	// ============================================================

	task automatic configure(logic [31:0] arm, logic [31:0] post,
		logic [31:0] mask, logic [31:0] value);
		@(posedge CLOCK_100);
		cfg_arm <= arm;
		cfg_post <= post;
		cfg_mask <= mask;
		cfg_value <= value;
		ctrl_mem[`LA_ADDR_ARM] <= arm;
		ctrl_mem[`LA_ADDR_POST] <= post;
		ctrl_mem[`LA_ADDR_MASK] <= mask;
		ctrl_mem[`LA_ADDR_VALUE] <= value;
		ctrl_mem[`LA_ADDR_NEW] <= 32'd1;
		@(posedge CLOCK_100);
		while (ctrl_mem[`LA_ADDR_NEW] != 0) @(posedge CLOCK_100);
	endtask

	task automatic finish_test(string name);
		// checker counts are settled by the falling edge
		@(negedge CLOCK_100);
		tests_run++;
		if (error_count != errors_before) begin
			tests_failed++;
			$display("test %0d %s: failed", tests_run, name);
		end
		else begin
			$display("test %0d %s: ok", tests_run, name);
		end
		errors_before = error_count;
	endtask

	initial begin
		CLOCK_100 = 1'b0;
		reset = 1'b1;
		data_input = '0;
		trigger_source = '0;
		ctrl_rdata = '0;
		force_en = 1'b0;
		force_pattern = 32'h5a5a_c3c3;
		{cfg_mask, cfg_value, cfg_post, cfg_arm} = '0;
		seed = 32'hacf8_50ca;
		cycles = 0;
		tests_run = 0;
		tests_failed = 0;
		errors_before = 0;
		post_list = '{100, 500, 900};
		for (int i = 0; i < 256; i++) begin
			ctrl_mem[i] = '0;
		end
		repeat (16) @(posedge CLOCK_100);
		reset <= 1'b0;

		// idle run across a full buffer wrap
		repeat (1100) @(posedge CLOCK_100);
		finish_test("idle wrap");

		// disarmed, pattern forced in bursts
		configure(32'd0, 32'd100, 32'hffff_ffff, 32'h5a5a_c3c3);
		for (int i = 0; i < 10; i++) begin
			repeat (190) @(posedge CLOCK_100);
			force_en <= 1'b1;
			repeat (10) @(posedge CLOCK_100);
			force_en <= 1'b0;
		end
		if (ctrl_mem[`LA_ADDR_DONE] != 0) begin
			$display("CHECK FAILED at %0t ns: capture completed while disarmed", $time);
			errors_before = -1;
		end
		finish_test("disarmed");

		foreach (post_list[i]) begin
			captures_before = capture_count;
			configure(32'd1, post_list[i], 32'h8000_0000, 32'h8000_0000);
			while (ctrl_mem[`LA_ADDR_DONE] != 1) @(posedge CLOCK_100);
			if (sample_mem[ctrl_mem[`LA_ADDR_TRIG][9:0]] != exp_sample) begin
				$display("CHECK FAILED at %0t ns: stored trigger word %h, expected %h",
					$time, sample_mem[ctrl_mem[`LA_ADDR_TRIG][9:0]], exp_sample);
				errors_before = -1;
			end
			// hold done for a while, memory must stay frozen
			repeat (40) @(posedge CLOCK_100);
			ctrl_mem[`LA_ADDR_DONE] <= 32'd0;
			while (capture_count == captures_before) @(negedge CLOCK_100);
			finish_test($sformatf("capture post %0d", post_list[i]));
		end

		repeat (20) @(negedge CLOCK_100);
		$display("tests %0d, failed %0d, check errors %0d",
			tests_run, tests_failed, error_count);
		if (tests_failed == 0 && error_count == 0) begin
			$display(">>> PASS");
		end
		else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== tb/la_checker.sv ====
`timescale 1ns/1ns
`include "la_config.svh"

module la_checker (
	input logic CLOCK_100,
	input logic reset,
	input logic [31:0] data_input,
	input logic [31:0] trigger_source,
	input logic [9:0] sample_addr,
	input logic [31:0] sample_wdata,
	input logic sample_write,
	input logic [7:0] ctrl_addr,
	input logic [31:0] ctrl_wdata,
	input logic ctrl_write,
	// host side config and mailbox words
	input logic [31:0] cfg_mask,
	input logic [31:0] cfg_value,
	input logic [31:0] cfg_post,
	input logic [31:0] cfg_arm,
	input logic [31:0] new_word,
	input logic [31:0] done_word,
	output int error_count,
	output int capture_count,
	output logic [31:0] exp_sample
);

	// capture phases as the reference sees them
	localparam int IDLE = 0, ARMED = 1, SAMPLE = 2, TRIG_WR = 3;
	localparam int COUNT = 4, REPORT = 5, DONE_WR = 6, FROZEN = 7;

	logic [31:0] src_hist [0:32767];
	logic [31:0] dat_hist [0:32767];
	int edge_n;
	int phase;
	int arm_edge;
	int writes_left;
	logic [9:0] ptr;
	logic [9:0] exp_addr;
	logic [31:0] mask;
	logic [31:0] value;
	logic [31:0] post;

	// ============================================================
	// reference model
	// ============================================================

	// first armed edge where the masked compare holds, -1 if none yet
	function automatic int trigger_edge(int from_edge, int last_edge);
		for (int e = from_edge; e <= last_edge; e++) begin
			if ((src_hist[e] & mask) == (value & mask)) begin
				return e;
			end
		end
		return -1;
	endfunction

	// writes after the trigger write, count truncated to 10 bits
	function automatic int post_writes(logic [31:0] count);
		return int'(count[9:0]) + 2;
	endfunction

	task automatic flag_mismatch(string msg);
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
		error_count++;
	endtask

	// ============================================================
	// comparing process
	// ============================================================

	always @(posedge CLOCK_100) begin
		int phase_in;
		int m;
		if (reset) begin
			edge_n = 0;
			phase = IDLE;
			ptr = '0;
		end
		else begin
			phase_in = phase;
			src_hist[edge_n] = trigger_source;
			dat_hist[edge_n] = data_input;

			// done word must follow the trigger address write directly
			if (phase_in == DONE_WR && !(ctrl_write && ctrl_addr == `LA_ADDR_DONE)) begin
				flag_mismatch("done word not written right after trigger address");
				phase = FROZEN;
			end

			// mailbox writes
			if (ctrl_write) begin
				case (ctrl_addr)
					`LA_ADDR_NEW: begin
						if (new_word == 0) begin
							flag_mismatch("word 0 cleared while it was already zero");
						end
						else if (cfg_arm != 0 && phase == IDLE) begin
							// arm is set by the edge that clears word 0
							mask = cfg_mask;
							value = cfg_value;
							post = cfg_post;
							arm_edge = edge_n;
							phase = ARMED;
						end
					end
					`LA_ADDR_TRIG: begin
						if (phase != REPORT) begin
							flag_mismatch("trigger address written with no capture finished");
						end
						else if (ctrl_wdata != {22'd0, exp_addr}) begin
							flag_mismatch($sformatf("word 251 got %0d, expected %0d",
								ctrl_wdata, exp_addr));
						end
						phase = DONE_WR;
					end
					`LA_ADDR_DONE: begin
						if (phase_in != DONE_WR || ctrl_wdata != 32'd1) begin
							flag_mismatch("unexpected write to the done word");
						end
						phase = FROZEN;
					end
					default: begin
						flag_mismatch($sformatf("write to control word %0d", ctrl_addr));
					end
				endcase
			end

			// capture reference
			case (phase)
				ARMED: begin
					m = trigger_edge(arm_edge, edge_n);
					if (m >= 0) begin
						phase = SAMPLE;
					end
				end
				SAMPLE: begin
					// the trigger word is the data one edge after the match
					exp_sample = dat_hist[edge_n];
					phase = TRIG_WR;
				end
				TRIG_WR: begin
					exp_addr = ptr;
					if (!sample_write || sample_wdata != exp_sample) begin
						flag_mismatch($sformatf("trigger write %h, expected %h",
							sample_wdata, exp_sample));
					end
					writes_left = post_writes(post);
					phase = COUNT;
				end
				COUNT: begin
					if (sample_write) begin
						writes_left--;
					end
					if (writes_left == 0) begin
						phase = REPORT;
					end
				end
				REPORT, DONE_WR, FROZEN: begin
					if (sample_write && phase_in != COUNT) begin
						flag_mismatch("sample write after the post-trigger count");
					end
					// done word lands in memory one edge after its write
					if (phase_in == FROZEN && done_word == 0) begin
						capture_count++;
						phase = IDLE;
					end
				end
				default: begin
				end
			endcase

			// consecutive addresses, wrapping at 1024
			if (sample_write) begin
				if (sample_addr != ptr) begin
					flag_mismatch($sformatf("sample address %0d, expected %0d",
						sample_addr, ptr));
				end
				ptr = ptr + 1'b1;
			end
			edge_n++;
		end
	end

	initial begin
		error_count = 0;
		capture_count = 0;
	end

endmodule

// ==== design/logic_analyser.sv ====
`timescale 1ns/1ns

module logic_analyser import la_pkg::*; (
	input logic CLOCK_100,
	input logic reset,
	// probed signals
	input sample_t data_input,
	input sample_t trigger_source,
	// sample memory, write only
	output sample_addr_t sample_addr,
	output sample_t sample_wdata,
	output logic sample_write,
	// control memory shared with the host
	output ctrl_addr_t ctrl_addr,
	output sample_t ctrl_wdata,
	output logic ctrl_write,
	input sample_t ctrl_rdata
);

	// ============================================================
	// internal wiring
	// ============================================================

	// config and completion between the three blocks
	la_ctrl_if u_ctrl_if ();

	// pending trigger and its ack
	logic trigger;
	logic trigger_taken;

	// input side
	trigger_qualifier u_trigger_qualifier (
		.CLOCK_100 (CLOCK_100),
		.reset (reset),
		.trigger_source (trigger_source),
		.ctrl (u_ctrl_if.trigger),
		.trigger_taken (trigger_taken),
		.trigger (trigger)
	);

	// circular buffer writer
	capture_engine u_capture_engine (
		.CLOCK_100 (CLOCK_100),
		.reset (reset),
		.data_input (data_input),
		.trigger (trigger),
		.trigger_taken (trigger_taken),
		.ctrl (u_ctrl_if.capture),
		.sample_addr (sample_addr),
		.sample_wdata (sample_wdata),
		.sample_write (sample_write)
	);

	// host side
	host_mailbox u_host_mailbox (
		.CLOCK_100 (CLOCK_100),
		.reset (reset),
		.ctrl (u_ctrl_if.mailbox),
		.ctrl_addr (ctrl_addr),
		.ctrl_wdata (ctrl_wdata),
		.ctrl_write (ctrl_write),
		.ctrl_rdata (ctrl_rdata)
	);

endmodule

// ==== design/host_mailbox.sv ====
`timescale 1ns/1ns
`include "la_config.svh"

module host_mailbox import la_pkg::*; (
	input logic CLOCK_100,
	input logic reset,
	la_ctrl_if.mailbox ctrl,
	output ctrl_addr_t ctrl_addr,
	output sample_t ctrl_wdata,
	output logic ctrl_write,
	input sample_t ctrl_rdata
);

	mailbox_state_e state;

	// release straight out of the done poll
	// complete then falls on the same edge the sequencer goes idle
	assign ctrl.capture_release = (state == MB_DONE_READ) && (ctrl_rdata == '0);

	// ============================================================
	// control sequencer
	// ============================================================
	// read data comes back one edge after the address
	// so every read is address, wait, read

	always_ff @(posedge CLOCK_100) begin
		if (reset) begin
			state <= MB_IDLE;
			ctrl_write <= 1'b0;
			ctrl.arm_load <= 1'b0;
		end
		else begin
			// strobes are single cycle
			ctrl_write <= 1'b0;
			ctrl.arm_load <= 1'b0;

			case (state)
				// finished capture wins over new config
				MB_IDLE: begin
					if (ctrl.complete) begin
						state <= MB_TRIG_WR;
					end
					else begin
						ctrl_addr <= ctrl_addr_t'(`LA_ADDR_NEW);
						state <= MB_NEW_WAIT;
					end
				end
				MB_NEW_WAIT: state <= MB_NEW_READ;
				MB_NEW_READ: begin
					// nonzero word 0 means new config
					state <= (ctrl_rdata != '0) ? MB_POST_ADDR : MB_IDLE;
				end

				// post-trigger count
				MB_POST_ADDR: begin
					ctrl_addr <= ctrl_addr_t'(`LA_ADDR_POST);
					state <= MB_POST_WAIT;
				end
				MB_POST_WAIT: state <= MB_POST_READ;
				MB_POST_READ: begin
					// only the low 10 bits fit the buffer
					ctrl.post_count <= ctrl_rdata[`LA_DEPTH_LOG2-1:0];
					state <= MB_MASK_ADDR;
				end

				// trigger mask
				MB_MASK_ADDR: begin
					ctrl_addr <= ctrl_addr_t'(`LA_ADDR_MASK);
					state <= MB_MASK_WAIT;
				end
				MB_MASK_WAIT: state <= MB_MASK_READ;
				MB_MASK_READ: begin
					ctrl.trig_mask <= ctrl_rdata;
					state <= MB_VALUE_ADDR;
				end

				// trigger value
				MB_VALUE_ADDR: begin
					ctrl_addr <= ctrl_addr_t'(`LA_ADDR_VALUE);
					state <= MB_VALUE_WAIT;
				end
				MB_VALUE_WAIT: state <= MB_VALUE_READ;
				MB_VALUE_READ: begin
					ctrl.trig_value <= ctrl_rdata;
					state <= MB_ARM_ADDR;
				end

				// arm goes last, mask and value are already in place
				MB_ARM_ADDR: begin
					ctrl_addr <= ctrl_addr_t'(`LA_ADDR_ARM);
					state <= MB_ARM_WAIT;
				end
				MB_ARM_WAIT: state <= MB_ARM_READ;
				MB_ARM_READ: begin
					ctrl.arm_value <= (ctrl_rdata != '0);
					ctrl.arm_load <= 1'b1;
					state <= MB_NEW_CLEAR;
				end

				// ack the config to the host
				MB_NEW_CLEAR: begin
					ctrl_addr <= ctrl_addr_t'(`LA_ADDR_NEW);
					ctrl_wdata <= '0;
					ctrl_write <= 1'b1;
					state <= MB_IDLE;
				end

				// report trigger address, then raise done
				MB_TRIG_WR: begin
					ctrl_addr <= ctrl_addr_t'(`LA_ADDR_TRIG);
					ctrl_wdata <= sample_t'(ctrl.trigger_addr);
					ctrl_write <= 1'b1;
					state <= MB_DONE_WR;
				end
				MB_DONE_WR: begin
					ctrl_addr <= ctrl_addr_t'(`LA_ADDR_DONE);
					ctrl_wdata <= sample_t'(1);
					ctrl_write <= 1'b1;
					state <= MB_DONE_ADDR;
				end

				// poll done until the host clears it
				MB_DONE_ADDR: begin
					ctrl_addr <= ctrl_addr_t'(`LA_ADDR_DONE);
					state <= MB_DONE_WAIT;
				end
				MB_DONE_WAIT: state <= MB_DONE_READ;
				MB_DONE_READ: begin
					state <= (ctrl_rdata == '0) ? MB_IDLE : MB_DONE_ADDR;
				end

				default: begin
					state <= MB_IDLE;
				end
			endcase
		end
	end

endmodule

// ==== design/capture_engine.sv ====
`timescale 1ns/1ns
`include "la_config.svh"

module capture_engine import la_pkg::*; (
	input logic CLOCK_100,
	input logic reset,
	input sample_t data_input,
	input logic trigger,
	output logic trigger_taken,
	la_ctrl_if.capture ctrl,
	output sample_addr_t sample_addr,
	output sample_t sample_wdata,
	output logic sample_write
);

	// ============================================================
	// state and counters
	// ============================================================

	capture_state_e state;
	// next address to fill, wraps at 1024
	sample_addr_t write_ptr;
	// one bit wider so a post count of 1023 still ends
	logic [`LA_DEPTH_LOG2:0] post_cnt;

	// ack only while free running
	// a trigger arriving in POST or DONE waits here
	assign trigger_taken = (state == RUN) && trigger;

	// ============================================================
	// capture machine
	// ============================================================

	always_ff @(posedge CLOCK_100) begin
		if (reset) begin
			state <= RUN;
			write_ptr <= '0;
			sample_write <= 1'b0;
			ctrl.complete <= 1'b0;
		end
		else begin
			// log one word per clock unless parked in DONE
			sample_write <= (state != DONE);
			if (state != DONE) begin
				sample_wdata <= data_input;
				sample_addr <= write_ptr;
				write_ptr <= write_ptr + 1'b1;
			end

			case (state)
				RUN: begin
					if (trigger) begin
						// the word written on this edge is the trigger sample
						ctrl.trigger_addr <= write_ptr;
						post_cnt <= '0;
						state <= POST;
					end
				end

				POST: begin
					// post_count+2 writes in total here
					if (post_cnt <= {1'b0, ctrl.post_count}) begin
						post_cnt <= post_cnt + 1'b1;
					end
					else begin
						// last write, then hand over to the host
						ctrl.complete <= 1'b1;
						state <= DONE;
					end
				end

				DONE: begin
					// memory frozen until the host is done reading
					if (ctrl.capture_release) begin
						ctrl.complete <= 1'b0;
						state <= RUN;
					end
				end

				default: begin
					state <= RUN;
				end
			endcase
		end
	end

endmodule

// ==== design/trigger_qualifier.sv ====
`timescale 1ns/1ns

module trigger_qualifier import la_pkg::*; (
	input logic CLOCK_100,
	input logic reset,
	input sample_t trigger_source,
	la_ctrl_if.trigger ctrl,
	input logic trigger_taken,
	output logic trigger
);

	// ============================================================
	// masked compare
	// ============================================================

	logic match;
	logic arm;

	// don't-care bits are zero in the mask
	assign match = ((trigger_source & ctrl.trig_mask) ==
		(ctrl.trig_value & ctrl.trig_mask));

	// ============================================================
	// arm and pending trigger
	// ============================================================

	always_ff @(posedge CLOCK_100) begin
		if (reset) begin
			arm <= 1'b0;
			trigger <= 1'b0;
		end
		else begin
			if (arm && match) begin
				// one shot, host has to rearm
				arm <= 1'b0;
				// pending until the capture engine takes it
				trigger <= 1'b1;
			end
			else begin
				if (ctrl.arm_load) begin
					arm <= ctrl.arm_value;
				end
				// engine acked in RUN
				if (trigger_taken) begin
					trigger <= 1'b0;
				end
			end
		end
	end

endmodule

// ==== design/la_ctrl_if.sv ====
`timescale 1ns/1ns

interface la_ctrl_if import la_pkg::*; ();

	// trigger setup from the host
	sample_t trig_mask;
	sample_t trig_value;
	// samples after the trigger, already truncated to 10 bits
	sample_addr_t post_count;

	// one-cycle arm load, value alongside
	logic arm_load;
	logic arm_value;

	// one-cycle pulse once the host has cleared the done word
	logic capture_release;

	// capture finished, level until release
	logic complete;
	sample_addr_t trigger_addr;

	modport mailbox (
		output trig_mask, trig_value, post_count,
		output arm_load, arm_value, capture_release,
		input complete, trigger_addr
	);

	modport trigger (
		input trig_mask, trig_value, arm_load, arm_value
	);

	modport capture (
		input post_count, capture_release,
		output complete, trigger_addr
	);

endinterface

// ==== design/la_pkg.sv ====
`include "la_config.svh"

package la_pkg;

	// logged sample, also trigger mask and value width
	typedef logic [`LA_SAMPLE_W-1:0] sample_t;
	// sample memory address, wraps at depth
	typedef logic [`LA_DEPTH_LOG2-1:0] sample_addr_t;
	// control memory address
	typedef logic [`LA_CTRL_AW-1:0] ctrl_addr_t;

	// capture engine: free run, post-trigger fill, wait for host
	typedef enum logic [1:0] {
		RUN,
		POST,
		DONE
	} capture_state_e;

	// mailbox sequencer, one step per state
	// reads take three steps: address, wait, read
	typedef enum logic [4:0] {
		MB_IDLE,
		MB_NEW_WAIT, MB_NEW_READ,
		MB_POST_ADDR, MB_POST_WAIT, MB_POST_READ,
		MB_MASK_ADDR, MB_MASK_WAIT, MB_MASK_READ,
		MB_VALUE_ADDR, MB_VALUE_WAIT, MB_VALUE_READ,
		MB_ARM_ADDR, MB_ARM_WAIT, MB_ARM_READ,
		MB_NEW_CLEAR,
		MB_TRIG_WR, MB_DONE_WR,
		MB_DONE_ADDR, MB_DONE_WAIT, MB_DONE_READ
	} mailbox_state_e;

endpackage

// ==== include/la_config.svh ====
`ifndef LA_CONFIG_SVH
`define LA_CONFIG_SVH

// ============================================================
// logic analyser geometry
// ============================================================

// one logged word per clock
`define LA_SAMPLE_W 32
// circular sample memory, 1024 words
`define LA_DEPTH_LOG2 10
// control memory, 256 words
`define LA_CTRL_AW 8

// ============================================================
// mailbox word addresses in the control memory
// ============================================================
`define LA_ADDR_NEW 0
`define LA_ADDR_ARM 1
`define LA_ADDR_POST 2
`define LA_ADDR_DONE 250
`define LA_ADDR_TRIG 251
`define LA_ADDR_MASK 254
`define LA_ADDR_VALUE 255

`endif
